/* cpuPkg.sv */
`default_nettype none

package cpuPkg;

    localparam int DataWidth    = 32;                  // Bus, register and PC width
    localparam int RegAddrWidth = 5;                   // 32 architectural registers

    localparam logic [DataWidth-1:0] ResetPc = 32'h00001000; // First fetch address

    // Primary opcodes
    localparam logic [5:0] OpRType = 6'b000000;
    localparam logic [5:0] OpLw    = 6'b100011;
    localparam logic [5:0] OpSw    = 6'b101011;
    localparam logic [5:0] OpBeq   = 6'b000100;
    localparam logic [5:0] OpBne   = 6'b000101;
    localparam logic [5:0] OpJ     = 6'b000010;

    // R-type function field
    localparam logic [5:0] FnAdd = 6'b100000;
    localparam logic [5:0] FnSub = 6'b100010;
    localparam logic [5:0] FnAnd = 6'b100100;
    localparam logic [5:0] FnOr  = 6'b100101;
    localparam logic [5:0] FnSlt = 6'b101010;

    // ALU operation codes, bit 2 means inverted second operand
    localparam logic [2:0] AluAnd = 3'b000;
    localparam logic [2:0] AluOr  = 3'b001;
    localparam logic [2:0] AluAdd = 3'b010;
    localparam logic [2:0] AluSub = 3'b110;
    localparam logic [2:0] AluSlt = 3'b111;

    // Next-PC source
    localparam logic [1:0] PcSeq    = 2'b00;           // PC+4
    localparam logic [1:0] PcBranch = 2'b01;           // PC+4 plus offset*4
    localparam logic [1:0] PcJump   = 2'b10;           // Region plus target*4

    // Sequencer states
    localparam logic [1:0] StFetch = 2'd0;             // Instruction bus cycle
    localparam logic [1:0] StExec  = 2'd1;             // Single decode/ALU cycle
    localparam logic [1:0] StMem   = 2'd2;             // Data bus cycle, lw/sw only

    // One instruction word, three field layouts
    typedef union packed {
        struct packed {
            logic [5:0]              opcode;
            logic [RegAddrWidth-1:0] rs;
            logic [RegAddrWidth-1:0] rt;
            logic [RegAddrWidth-1:0] rd;
            logic [4:0]              shamt;
            logic [5:0]              funct;
        } r;
        struct packed {
            logic [5:0]              opcode;
            logic [RegAddrWidth-1:0] rs;
            logic [RegAddrWidth-1:0] rt;
            logic [15:0]             imm;    // Offset or ALU immediate
        } i;
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] target;             // Word index inside 256 MB region
        } j;
    } instrT;

endpackage

`default_nettype wire

/* aluUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module aluUnit import cpuPkg::*; (
    input  wire  instrT          instr,
    input  wire  [DataWidth-1:0] rsData,
    input  wire  [DataWidth-1:0] rtData,
    input  wire                  aluSrcImm,  // Immediate as second operand
    input  wire  [2:0]           aluOp,
    output logic [DataWidth-1:0] aluResult,
    output logic                 aluZero
);

    logic [DataWidth-1:0] immExt;            // Sign-extended immediate
    logic [DataWidth-1:0] opA;
    logic [DataWidth-1:0] opB;

    assign immExt = {{(DataWidth-16){instr.i.imm[15]}}, instr.i.imm};
    assign opA    = rsData;
    assign opB    = aluSrcImm ? immExt : rtData;

    always_comb begin
        case (aluOp)
            AluAnd:  aluResult = opA & opB;
            AluOr:   aluResult = opA | opB;
            AluAdd:  aluResult = opA + opB;              // Also address calculation
            AluSub:  aluResult = opA - opB;              // beq/bne compare
            AluSlt: begin
                // Signed compare, result is 0 or 1
                aluResult = ($signed(opA) < $signed(opB)) ? DataWidth'(1) : '0;
            end
            default: aluResult = '0;
        endcase
    end

    assign aluZero = (aluResult == '0);

endmodule

`default_nettype wire

/* registerFile.sv */
`timescale 1ns/1ps
`default_nettype none

module registerFile import cpuPkg::*; (
    input  wire                  Clk,
    input  wire                  reset,
    input  wire  instrT          instr,
    input  wire                  regWrite,
    input  wire                  regDst,     // rd for R-type, rt for lw
    input  wire                  memToReg,
    input  wire  [DataWidth-1:0] aluResult,
    input  wire  [DataWidth-1:0] loadData,
    output logic [DataWidth-1:0] rsData,
    output logic [DataWidth-1:0] rtData
);

    logic [DataWidth-1:0]    regs [2**RegAddrWidth];
    logic [RegAddrWidth-1:0] writeAddr;
    logic [DataWidth-1:0]    writeData;

    assign writeAddr = regDst ? instr.r.rd : instr.r.rt;
    assign writeData = memToReg ? loadData : aluResult;

    // Combinational reads, $zero hardwired
    assign rsData = (instr.r.rs == '0) ? '0 : regs[instr.r.rs];
    assign rtData = (instr.r.rt == '0) ? '0 : regs[instr.r.rt];

    always_ff @(posedge Clk) begin
        if (reset) begin
            for (int idx = 0; idx < 2**RegAddrWidth; idx++) begin
                regs[idx] <= '0;
            end
        end else if (regWrite && (writeAddr != '0)) begin
            regs[writeAddr] <= writeData;                // Writes to $zero dropped
        end
    end

endmodule

`default_nettype wire

/* nextPcLogic.sv */
`timescale 1ns/1ps
`default_nettype none

module nextPcLogic import cpuPkg::*; (
    input  wire                  Clk,
    input  wire                  reset,
    input  wire  instrT          instr,
    input  wire  [1:0]           pcSel,
    input  wire                  pcAdvance,  // Load next PC this edge
    output logic [DataWidth-1:0] pc
);

    logic [DataWidth-1:0] pcPlus4;
    logic [DataWidth-1:0] branchOffset;      // Offset in bytes
    logic [DataWidth-1:0] branchTarget;
    logic [DataWidth-1:0] jumpTarget;
    logic [DataWidth-1:0] pcNext;

    assign pcPlus4      = pc + DataWidth'(4);
    assign branchOffset = {{(DataWidth-18){instr.i.imm[15]}}, instr.i.imm, 2'b00};
    assign branchTarget = pcPlus4 + branchOffset;
    // Keep region bits of PC+4
    assign jumpTarget   = {pcPlus4[DataWidth-1:28], instr.j.target, 2'b00};

    always_comb begin
        case (pcSel)
            PcBranch: pcNext = branchTarget;
            PcJump:   pcNext = jumpTarget;
            default:  pcNext = pcPlus4;                  // PcSeq
        endcase
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            pc <= ResetPc;
        end else if (pcAdvance) begin
            pc <= pcNext;                                // Once per instruction
        end
    end

endmodule

`default_nettype wire

/* coreControl.sv */
`timescale 1ns/1ps
`default_nettype none

module coreControl import cpuPkg::*; (
    input  wire                  Clk,
    input  wire                  reset,
    input  wire  [DataWidth-1:0] wbDatIn,
    input  wire                  wbAck,
    input  wire  [DataWidth-1:0] pc,
    input  wire  [DataWidth-1:0] aluResult,  // Also the lw/sw address
    input  wire                  aluZero,
    output instrT                instr,
    output logic                 regWrite,
    output logic                 regDst,     // 1 selects rd, 0 selects rt
    output logic                 memToReg,
    output logic                 aluSrcImm,
    output logic [2:0]           aluOp,
    output logic [1:0]           pcSel,
    output logic                 pcAdvance,  // Last cycle of an instruction
    output logic                 wbCyc,
    output logic                 wbStb,
    output logic                 wbWe,
    output logic [DataWidth-1:0] wbAdr
);

    logic [1:0] state;
    logic       busReq;                      // Drives cyc and stb together
    logic       fetchDone;
    logic       memDone;
    logic       memAccess;                   // lw or sw
    logic       isLw;
    logic       isSw;
    logic       execWrite;                   // Write-back at end of execute
    logic [1:0] execSel;                     // PC source chosen in execute

    assign isLw      = (instr.r.opcode == OpLw);
    assign isSw      = (instr.r.opcode == OpSw);
    assign memAccess = isLw || isSw;
    assign fetchDone = (state == StFetch) && busReq && wbAck;
    assign memDone   = (state == StMem) && busReq && wbAck;

    // Main decoder, unknown codes fall through as no-ops
    always_comb begin
        aluOp     = AluAdd;
        regDst    = 1'b0;
        memToReg  = 1'b0;
        aluSrcImm = 1'b0;
        execWrite = 1'b0;
        execSel   = PcSeq;
        case (instr.r.opcode)
            OpRType: begin
                regDst    = 1'b1;
                execWrite = 1'b1;
                case (instr.r.funct)
                    FnAdd:   aluOp = AluAdd;
                    FnSub:   aluOp = AluSub;
                    FnAnd:   aluOp = AluAnd;
                    FnOr:    aluOp = AluOr;
                    FnSlt:   aluOp = AluSlt;
                    default: execWrite = 1'b0;           // Unknown funct, no write
                endcase
            end
            OpLw: begin
                aluSrcImm = 1'b1;                        // Base plus offset
                memToReg  = 1'b1;
            end
            OpSw:  aluSrcImm = 1'b1;
            OpBeq: begin
                aluOp = AluSub;                          // Compare by subtraction
                if (aluZero) execSel = PcBranch;
            end
            OpBne: begin
                aluOp = AluSub;
                if (!aluZero) execSel = PcBranch;
            end
            OpJ:     execSel = PcJump;
            default: ;
        endcase
    end

    // Strobes qualified by sequencer state
    assign regWrite  = ((state == StExec) && execWrite) || (memDone && isLw);
    assign pcSel     = (state == StExec) ? execSel : PcSeq;
    assign pcAdvance = ((state == StExec) && !memAccess) || memDone;

    // Bus master outputs
    assign wbCyc = busReq;
    assign wbStb = busReq;
    assign wbWe  = busReq && (state == StMem) && isSw;
    assign wbAdr = (state == StMem) ? aluResult : pc;  // Data or instruction address

    // Sequencer, one instruction in flight
    always_ff @(posedge Clk) begin
        if (reset) begin
            state  <= StFetch;
            busReq <= 1'b0;
        end else begin
            case (state)
                StFetch: begin
                    if (fetchDone) begin
                        busReq <= 1'b0;                  // Drop cycle after ack
                        state  <= StExec;
                    end else begin
                        busReq <= 1'b1;                  // Start or hold fetch
                    end
                end
                StExec: begin
                    if (memAccess) begin
                        busReq <= 1'b1;                  // Open data cycle
                        state  <= StMem;
                    end else begin
                        state <= StFetch;
                    end
                end
                StMem: begin
                    if (memDone) begin
                        busReq <= 1'b0;
                        state  <= StFetch;
                    end
                end
                default: state <= StFetch;
            endcase
        end
    end

    // Instruction register
    always_ff @(posedge Clk) begin
        if (fetchDone) instr <= wbDatIn;
    end

endmodule

`default_nettype wire

/* mipsCore.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsCore import cpuPkg::*; (
    input  wire                  Clk,
    input  wire                  reset,
    input  wire  [DataWidth-1:0] wbDatIn,   // Fetched word or load data
    input  wire                  wbAck,
    output logic                 wbCyc,
    output logic                 wbStb,
    output logic                 wbWe,
    output logic [DataWidth-1:0] wbAdr,
    output logic [DataWidth-1:0] wbDatOut   // Store data
);

    instrT                instr;             // Current instruction register
    logic                 regWrite;
    logic                 regDst;
    logic                 memToReg;
    logic                 aluSrcImm;
    logic [2:0]           aluOp;
    logic [1:0]           pcSel;
    logic                 pcAdvance;
    logic [DataWidth-1:0] aluResult;
    logic                 aluZero;
    logic [DataWidth-1:0] rsData;
    logic [DataWidth-1:0] rtData;
    logic [DataWidth-1:0] pc;

    coreControl control (
        .Clk(Clk), .reset(reset),
        .wbDatIn(wbDatIn), .wbAck(wbAck),
        .pc(pc), .aluResult(aluResult), .aluZero(aluZero),
        .instr(instr),
        .regWrite(regWrite), .regDst(regDst), .memToReg(memToReg),
        .aluSrcImm(aluSrcImm), .aluOp(aluOp),
        .pcSel(pcSel), .pcAdvance(pcAdvance),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr)
    );

    registerFile regs (
        .Clk(Clk), .reset(reset),
        .instr(instr),
        .regWrite(regWrite), .regDst(regDst), .memToReg(memToReg),
        .aluResult(aluResult),
        .loadData(wbDatIn),                  // Load word straight off the bus
        .rsData(rsData), .rtData(rtData)
    );

    aluUnit alu (
        .instr(instr),
        .rsData(rsData), .rtData(rtData),
        .aluSrcImm(aluSrcImm), .aluOp(aluOp),
        .aluResult(aluResult), .aluZero(aluZero)
    );

    nextPcLogic nextPc (
        .Clk(Clk), .reset(reset),
        .instr(instr),
        .pcSel(pcSel), .pcAdvance(pcAdvance),
        .pc(pc)
    );

    assign wbDatOut = rtData;                // sw writes rt

endmodule

`default_nettype wire

/* wbMemModel.sv */
`timescale 1ns/1ps
`default_nettype none

module wbMemModel import cpuPkg::*; (
    input  wire                  Clk,
    input  wire                  reset,
    input  wire                  randomDelay, // 0 to 3 wait cycles per access
    input  wire                  wbCyc,
    input  wire                  wbStb,
    input  wire                  wbWe,
    input  wire  [DataWidth-1:0] wbAdr,
    input  wire  [DataWidth-1:0] wbWrData,    // Master store data
    output logic [DataWidth-1:0] wbRdData,
    output logic                 wbAck
);

    logic [DataWidth-1:0] words [4096];               // Loaded image, 16 KB
    logic [DataWidth-1:0] storedWords [logic [11:0]]; // Words written by the core
    logic [DataWidth-1:0] storeAddr [$];
    logic [DataWidth-1:0] storeData [$];
    logic [DataWidth-1:0] fetchAddr [$];              // Reads inside the code region
    logic [11:0]          wordIdx;
    logic                 busy;                       // Access seen, ack pending
    int                   waitCnt;
    integer               seed = 32'ha4e3;

    assign wordIdx = wbAdr[13:2];

    initial begin
        wbAck    = 1'b0;
        wbRdData = '0;
    end

    task automatic fillMem();
        for (int i = 0; i < 4096; i++) begin
            words[i] = 32'hc0de0000 ^ 32'(i * 4);     // Decodes as an unknown opcode
        end
    endtask

    task automatic loadWord(input logic [DataWidth-1:0] addr, input logic [DataWidth-1:0] data);
        words[addr[13:2]] = data;
    endtask

    always @(posedge Clk) begin : slave
        int delay;
        if (reset) begin
            wbAck    <= #1 1'b0;
            wbRdData <= #1 '0;
            busy     <= 1'b0;
            waitCnt  <= 0;
            storedWords.delete();                     // Fresh image and logs per test
            storeAddr.delete();
            storeData.delete();
            fetchAddr.delete();
        end else if (wbAck) begin
            wbAck <= #1 1'b0;                         // Single-cycle ack
            busy  <= 1'b0;
        end else if (wbCyc && wbStb) begin
            delay = busy ? waitCnt : (randomDelay ? int'($unsigned($random(seed)) % 4) : 0);
            busy <= 1'b1;
            if (delay == 0) begin
                wbAck <= #1 1'b1;
                if (wbWe) begin
                    storedWords[wordIdx] = wbWrData;
                    storeAddr.push_back(wbAdr);
                    storeData.push_back(wbWrData);
                end else begin
                    wbRdData <= #1 storedWords.exists(wordIdx) ? storedWords[wordIdx]
                                                               : words[wordIdx];
                    if ((wbAdr >= ResetPc) && (wbAdr < ResetPc + 32'h00001000)) begin
                        fetchAddr.push_back(wbAdr);
                    end
                end
            end else begin
                waitCnt <= delay - 1;
            end
        end
    end

endmodule

`default_nettype wire

/* coreTb.sv */
`timescale 1ns/1ps
`default_nettype none

module coreTb import cpuPkg::*; ();

    logic                 Clk = 1'b0;
    logic                 reset = 1'b1;
    logic                 randomDelay = 1'b0;
    logic                 wbCyc;
    logic                 wbStb;
    logic                 wbWe;
    logic                 wbAck;
    logic [DataWidth-1:0] wbAdr;
    logic [DataWidth-1:0] wbDatOut;
    logic [DataWidth-1:0] wbDatIn;
    logic [DataWidth-1:0] progPtr;                    // Next program word address
    logic [DataWidth-1:0] argA = 32'h800000f5;        // Negative operand
    logic [DataWidth-1:0] argB = 32'h00007f3c;
    int                   errors = 0;

    always #2 Clk = ~Clk;

    mipsCore uut (
        .Clk(Clk), .reset(reset), .wbDatIn(wbDatIn), .wbAck(wbAck),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatOut(wbDatOut)
    );

    wbMemModel memory (
        .Clk(Clk), .reset(reset), .randomDelay(randomDelay),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
        .wbWrData(wbDatOut), .wbRdData(wbDatIn), .wbAck(wbAck)
    );

    function automatic instrT rType(input logic [5:0] fn, input logic [4:0] rd, rs, rt);
        instrT w;
        w.r = '{OpRType, rs, rt, rd, 5'd0, fn};
        return w;
    endfunction

    function automatic instrT iType(input logic [5:0] op, input logic [4:0] rs, rt,
                                    input logic [15:0] imm);
        instrT w;
        w.i = '{op, rs, rt, imm};
        return w;
    endfunction

    function automatic instrT jType(input logic [DataWidth-1:0] dest);
        instrT w;
        w.j = '{OpJ, dest[27:2]};                     // Word index of the destination
        return w;
    endfunction

    function automatic logic [DataWidth-1:0] pcOf(input int k);
        return ResetPc + 32'(4 * k);
    endfunction

    function automatic logic [DataWidth-1:0] offsetAddr(input logic [DataWidth-1:0] base,
                                                        input logic [15:0] off);
        return base + {{16{off[15]}}, off};
    endfunction

    function automatic logic [DataWidth-1:0] branchTarget(input logic [DataWidth-1:0] pcVal,
                                                          input logic [15:0] off);
        return pcVal + 32'd4 + {{14{off[15]}}, off, 2'b00};
    endfunction

    function automatic logic [DataWidth-1:0] jumpTarget(input logic [DataWidth-1:0] pcVal,
                                                        input logic [25:0] tgt);
        logic [DataWidth-1:0] next;
        next = pcVal + 32'd4;
        return {next[31:28], tgt, 2'b00};             // Region of PC+4
    endfunction

    task automatic checkAddr(input string name, input logic [DataWidth-1:0] exp, act);
        if (act !== exp) begin
            errors++;
            $display("MISMATCH at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic checkData(input string name, input logic [DataWidth-1:0] exp, act);
        if (act !== exp) begin
            errors++;
            $display("MISMATCH at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic emit(input instrT w);
        memory.loadWord(progPtr, w);
        progPtr = progPtr + 32'd4;
    endtask

    task automatic beginTest(input logic slowAck);
        @(posedge Clk);
        #1;
        reset       = 1'b1;
        randomDelay = slowAck;
        @(posedge Clk);
        memory.fillMem();                             // Core and memory held in reset
        progPtr = ResetPc;
    endtask

    task automatic releaseReset();
        @(posedge Clk);
        #1;
        checkData("wbCyc in reset", '0, DataWidth'(wbCyc));
        reset = 1'b0;
        @(posedge Clk);
        #1;
        checkData("wbStb after reset", 32'd1, DataWidth'(wbStb)); // First fetch at once
    endtask

    task automatic waitStores(input int count, input string what);
        int cycles;
        cycles = 0;
        while ((memory.storeAddr.size() < count) && (cycles < 400)) begin
            @(posedge Clk);
            cycles++;
        end
        if (memory.storeAddr.size() < count) begin
            errors++;
            $display("Timeout: store %0d of the %s test never arrived",
                     memory.storeAddr.size() + 1, what);
        end
    endtask

    task automatic checkStore(input int idx, input logic [DataWidth-1:0] expAddr, expData);
        checkAddr($sformatf("store %0d wbAdr", idx), expAddr, memory.storeAddr[idx]);
        checkData($sformatf("store %0d wbDatOut", idx), expData, memory.storeData[idx]);
    endtask

    task automatic checkFetchAfter(input logic [DataWidth-1:0] fromPc, expNext);
        int pos;
        pos = -1;
        for (int i = 0; i < memory.fetchAddr.size(); i++) begin
            if ((pos < 0) && (memory.fetchAddr[i] == fromPc)) pos = i;
        end
        if ((pos < 0) || (pos + 1 >= memory.fetchAddr.size())) begin
            errors++;
            $display("No fetch followed the fetch of address %h", fromPc);
        end else begin
            checkAddr($sformatf("fetch after %h", fromPc), expNext, memory.fetchAddr[pos + 1]);
        end
    endtask

    task automatic resetFetchTest();
        beginTest(1'b0);
        emit(rType(FnAdd, 5'd1, 5'd0, 5'd0));
        emit(rType(FnOr, 5'd2, 5'd0, 5'd0));
        emit(iType(OpSw, 5'd0, 5'd0, 16'h3100));
        emit(jType(progPtr));                         // Park in a self loop
        releaseReset();
        waitStores(1, "reset");
        for (int k = 0; k < 3; k++) begin
            checkAddr($sformatf("fetch %0d wbAdr", k), pcOf(k), memory.fetchAddr[k]);
        end
        checkStore(0, 32'h00003100, '0);
    endtask

    task automatic loadArith();
        memory.loadWord(32'h00003000, argA);
        memory.loadWord(32'h00003004, argB);
        emit(iType(OpLw, 5'd0, 5'd1, 16'h3000));
        emit(iType(OpLw, 5'd0, 5'd2, 16'h3004));
        emit(rType(FnAdd, 5'd3, 5'd1, 5'd2));
        emit(rType(FnSub, 5'd4, 5'd1, 5'd2));
        emit(rType(FnAnd, 5'd5, 5'd1, 5'd2));
        emit(rType(FnOr, 5'd6, 5'd1, 5'd2));
        emit(rType(FnSlt, 5'd7, 5'd1, 5'd2));
        emit(rType(FnSlt, 5'd8, 5'd2, 5'd1));        // Swapped operands
        for (int r = 3; r <= 8; r++) begin
            emit(iType(OpSw, 5'd0, 5'(r), 16'(32'h3100 + 4 * (r - 3))));
        end
        emit(jType(progPtr));
    endtask

    task automatic checkArithStores();
        logic [DataWidth-1:0] want [6];
        want[0] = argA + argB;
        want[1] = argA - argB;
        want[2] = argA & argB;
        want[3] = argA | argB;
        want[4] = ($signed(argA) < $signed(argB)) ? 32'd1 : 32'd0;
        want[5] = ($signed(argB) < $signed(argA)) ? 32'd1 : 32'd0;
        checkData("store count", 32'd6, 32'(memory.storeAddr.size()));
        for (int k = 0; k < 6; k++) begin
            checkStore(k, 32'h00003100 + 32'(4 * k), want[k]);
        end
    endtask

    task automatic arithTest();
        beginTest(1'b0);
        loadArith();
        releaseReset();
        waitStores(6, "arithmetic");
        checkArithStores();
    endtask

    task automatic loadStoreTest();
        logic [DataWidth-1:0] base;
        logic [DataWidth-1:0] d1;
        logic [DataWidth-1:0] d2;
        base = 32'h00003200;
        d1   = 32'h5eed1234;
        d2   = 32'h0badf00d;
        beginTest(1'b0);
        memory.loadWord(32'h00003000, base);
        memory.loadWord(offsetAddr(base, 16'h0010), d1);
        memory.loadWord(offsetAddr(base, 16'hfff8), d2);
        emit(iType(OpLw, 5'd0, 5'd1, 16'h3000));
        emit(iType(OpLw, 5'd1, 5'd2, 16'h0010));      // Positive offset
        emit(iType(OpLw, 5'd1, 5'd3, 16'hfff8));      // Negative offset
        emit(iType(OpSw, 5'd1, 5'd2, 16'h0020));
        emit(iType(OpSw, 5'd1, 5'd3, 16'hffe0));
        emit(iType(OpLw, 5'd1, 5'd4, 16'h0020));      // Reload the stored word
        emit(iType(OpSw, 5'd1, 5'd4, 16'h0030));
        emit(rType(FnAdd, 5'd0, 5'd2, 5'd3));         // Writes to $zero
        emit(iType(OpLw, 5'd1, 5'd0, 16'h0010));
        emit(iType(OpSw, 5'd1, 5'd0, 16'h0040));
        emit(jType(progPtr));
        releaseReset();
        waitStores(4, "load/store");
        checkStore(0, offsetAddr(base, 16'h0020), d1);
        checkStore(1, offsetAddr(base, 16'hffe0), d2);
        checkStore(2, offsetAddr(base, 16'h0030), d1);
        checkStore(3, offsetAddr(base, 16'h0040), '0);
    endtask

    task automatic branchTest();
        logic [DataWidth-1:0] x;
        logic [DataWidth-1:0] y;
        x = 32'h13579bdf;
        y = 32'h2468ace0;
        beginTest(1'b0);
        memory.loadWord(32'h00003000, x);
        memory.loadWord(32'h00003004, x);
        memory.loadWord(32'h00003008, y);
        emit(iType(OpLw, 5'd0, 5'd1, 16'h3000));
        emit(iType(OpLw, 5'd0, 5'd2, 16'h3004));
        emit(iType(OpLw, 5'd0, 5'd3, 16'h3008));
        emit(iType(OpBeq, 5'd1, 5'd2, 16'd1));        // Taken
        emit(iType(OpSw, 5'd0, 5'd1, 16'h3100));
        emit(iType(OpSw, 5'd0, 5'd1, 16'h3104));
        emit(iType(OpBeq, 5'd1, 5'd3, 16'd1));        // Not taken
        emit(iType(OpSw, 5'd0, 5'd3, 16'h3108));
        emit(iType(OpBne, 5'd1, 5'd3, 16'd1));        // Taken
        emit(iType(OpSw, 5'd0, 5'd3, 16'h310c));
        emit(iType(OpSw, 5'd0, 5'd2, 16'h3110));
        emit(iType(OpBne, 5'd1, 5'd2, 16'd1));        // Not taken
        emit(iType(OpSw, 5'd0, 5'd3, 16'h3114));
        emit(jType(progPtr));
        releaseReset();
        waitStores(4, "branch");
        checkStore(0, 32'h00003104, x);
        checkStore(1, 32'h00003108, y);
        checkStore(2, 32'h00003110, x);
        checkStore(3, 32'h00003114, y);
        checkFetchAfter(pcOf(3), branchTarget(pcOf(3), 16'd1));
        checkFetchAfter(pcOf(6), pcOf(7));
        checkFetchAfter(pcOf(8), branchTarget(pcOf(8), 16'd1));
        checkFetchAfter(pcOf(11), pcOf(12));
    endtask

    task automatic jumpTest();
        logic [DataWidth-1:0] value;
        instrT                jumpWord;
        value    = 32'hfeedc0de;
        jumpWord = jType(pcOf(4));
        beginTest(1'b0);
        memory.loadWord(32'h00003000, value);
        emit(iType(OpLw, 5'd0, 5'd1, 16'h3000));
        emit(jumpWord);
        emit(iType(OpSw, 5'd0, 5'd1, 16'h3100));      // Skipped
        emit(iType(OpSw, 5'd0, 5'd1, 16'h3104));      // Skipped
        emit(iType(OpSw, 5'd0, 5'd1, 16'h3108));
        emit(jType(progPtr));
        releaseReset();
        waitStores(1, "jump");
        checkStore(0, 32'h00003108, value);
        checkFetchAfter(pcOf(1), jumpTarget(pcOf(1), jumpWord.j.target));
    endtask

    task automatic backPressureTest();
        beginTest(1'b1);
        loadArith();
        releaseReset();
        waitStores(6, "back-pressure");
        checkArithStores();
    endtask

    initial begin
        resetFetchTest();
        arithTest();
        loadStoreTest();
        branchTest();
        jumpTest();
        backPressureTest();
        $display("Directed tests done, %0d errors", errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
cpuPkg.sv
aluUnit.sv
registerFile.sv
nextPcLogic.sv
coreControl.sv
mipsCore.sv
wbMemModel.sv
coreTb.sv

/* runSim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module coreTb -f files.f -o coreTbSim
./obj_dir/coreTbSim > sim.log
cat sim.log

if grep -qx "NO ERRORS" sim.log; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed"
exit 1
